// ==== Bender.yml ====
package:
  name: avalon_mem

sources:
  - mem_bus_pkg.sv
  - mem_req_pkg.sv
  - mem_cmd_if.sv
  - mem_req_decode.sv
  - avalon_burst_exec.sv
  - read_result_assemble.sv
  - avalon_mem.sv
  - target: test
    files:
      - tb_avalon_mem.sv

// ==== avalon_burst_exec.sv ====
`timescale 1ns/1ps

module avalon_burst_exec #(
   parameter int CODE_BEATS = 8
) (
   input  logic                                  clk,
   input  logic                                  rst_n,

   // Decoded command in, beat stream out
   mem_cmd_if.exe                                cmd,

   // Avalon slave response
   input  logic                                  avm_waitrequest,
   input  logic                                  avm_readdatavalid,
   input  logic [mem_bus_pkg::AVM_DATA_W-1:0]    avm_readdata,

   // Avalon master command
   output logic [31:2]                           avm_address,
   output logic [mem_bus_pkg::AVM_DATA_W-1:0]    avm_writedata,
   output logic [mem_bus_pkg::AVM_BE_W-1:0]      avm_byteenable,
   output mem_bus_pkg::avm_burst_t               avm_burstcount,
   output logic                                  avm_write,
   output logic                                  avm_read,

   // Completion strobes
   output logic                                  writeburst_done,
   output logic                                  readburst_done,
   output logic                                  readcode_done
);

   // Beat counter start for a code line
   localparam logic [2:0] CODE_LAST = 3'(CODE_BEATS - 1);

   mem_bus_pkg::mem_state_t               state;
   logic [2:0]                            counter;
   mem_req_pkg::dword_len_t               rd_len;

   // Second write dword, held across the WRITE phase
   logic [mem_bus_pkg::AVM_ADDR_W-1:0]    wr_addr_next;
   logic [mem_bus_pkg::AVM_DATA_W-1:0]    wr_data_next;
   logic [mem_bus_pkg::AVM_BE_W-1:0]      wr_be_next;

   logic                                  in_idle;
   logic                                  is_write;
   logic                                  is_read;
   logic                                  is_code;

   assign in_idle  = (state == mem_bus_pkg::IDLE);
   assign is_write = (cmd.cmd.kind == mem_req_pkg::WRITE);
   assign is_read  = (cmd.cmd.kind == mem_req_pkg::READ);
   assign is_code  = (cmd.cmd.kind == mem_req_pkg::CODE);

   // ------------------------------
   // Avalon command phase
   // ------------------------------
   // IDLE shows the live command, WRITE the saved second dword
   assign avm_address    = (state == mem_bus_pkg::WRITE) ? wr_addr_next : cmd.cmd.addr_0;
   assign avm_writedata  = (state == mem_bus_pkg::WRITE) ? wr_data_next : cmd.cmd.wdata_0;
   assign avm_byteenable = (state == mem_bus_pkg::WRITE) ? wr_be_next : cmd.cmd.be_0;
   assign avm_burstcount = (state == mem_bus_pkg::WRITE) ? 4'd1 : cmd.cmd.burst;

   assign avm_write = (in_idle && is_write) || (state == mem_bus_pkg::WRITE);
   assign avm_read  = in_idle && (is_read || is_code);

   // ------------------------------
   // Done strobes
   // ------------------------------
   // Write is done once its first dword is taken
   assign writeburst_done = in_idle && is_write && !avm_waitrequest;
   assign readburst_done  = (state == mem_bus_pkg::READ) && (counter == 3'd0)
                            && avm_readdatavalid;
   // One strobe per code beat
   assign readcode_done   = (state == mem_bus_pkg::READ_CODE) && avm_readdatavalid;

   // Data burst beats to the result stage
   assign cmd.beat_valid = (state == mem_bus_pkg::READ) && avm_readdatavalid;
   assign cmd.beat_index = counter;
   assign cmd.beat_data  = avm_readdata;
   assign cmd.beat_len   = rd_len;

   // ------------------------------
   // Master FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= mem_bus_pkg::IDLE;
         counter <= 3'd0;
         rd_len  <= 2'd0;
      end else begin
         case (state)
            mem_bus_pkg::IDLE: begin
               // Nothing moves while the slave stalls
               if (!avm_waitrequest) begin
                  if (is_write) begin
                     if (cmd.cmd.dword_len > 2'd1) begin
                        state <= mem_bus_pkg::WRITE;
                     end
                  end else if (is_read) begin
                     state   <= mem_bus_pkg::READ;
                     counter <= {1'b0, cmd.cmd.dword_len} - 3'd1;
                     rd_len  <= cmd.cmd.dword_len;
                  end else if (is_code) begin
                     state   <= mem_bus_pkg::READ_CODE;
                     counter <= CODE_LAST;
                  end
               end
            end
            mem_bus_pkg::WRITE: begin
               if (!avm_waitrequest) begin
                  state <= mem_bus_pkg::IDLE;
               end
            end
            default: begin
               // READ and READ_CODE count beats down to 0
               if (avm_readdatavalid) begin
                  counter <= counter - 3'd1;
                  if (counter == 3'd0) begin
                     state <= mem_bus_pkg::IDLE;
                  end
               end
            end
         endcase
      end
   end

   // Second dword captured with the first one
   always_ff @(posedge clk) begin
      if (in_idle && is_write && !avm_waitrequest) begin
         wr_addr_next <= cmd.cmd.addr_1;
         wr_data_next <= cmd.cmd.wdata_1;
         wr_be_next   <= cmd.cmd.be_1;
      end
   end

endmodule

// ==== avalon_mem.sv ====
`timescale 1ns/1ps

module avalon_mem #(
   // Code line length in dwords, 4 or 8
   parameter int CODE_BEATS = 8
) (
   input  logic          clk,
   input  logic          rst_n,

   // Write burst requester
   input  logic          writeburst_do,
   output logic          writeburst_done,
   input  logic [31:0]   writeburst_address,
   input  logic [1:0]    writeburst_dword_length,
   input  logic [3:0]    writeburst_byteenable_0,
   input  logic [3:0]    writeburst_byteenable_1,
   input  logic [55:0]   writeburst_data,

   // Read burst requester
   input  logic          readburst_do,
   output logic          readburst_done,
   input  logic [31:0]   readburst_address,
   input  logic [1:0]    readburst_dword_length,
   input  logic [3:0]    readburst_byte_length,
   output logic [95:0]   readburst_data,

   // Code line requester
   input  logic          readcode_do,
   output logic          readcode_done,
   input  logic [31:0]   readcode_address,
   output logic [31:0]   readcode_partial,

   // Avalon-MM master
   output logic [31:2]   avm_address,
   output logic [31:0]   avm_writedata,
   output logic [3:0]    avm_byteenable,
   output logic [3:0]    avm_burstcount,
   output logic          avm_write,
   output logic          avm_read,
   input  logic          avm_waitrequest,
   input  logic          avm_readdatavalid,
   input  logic [31:0]   avm_readdata
);

   mem_cmd_if link ();

   // ------------------------------
   // Decode, combinational
   // ------------------------------
   mem_req_decode #(
      .CODE_BEATS (CODE_BEATS)
   ) u_decode (
      .writeburst_do           (writeburst_do),
      .writeburst_address      (writeburst_address),
      .writeburst_dword_length (writeburst_dword_length),
      .writeburst_byteenable_0 (writeburst_byteenable_0),
      .writeburst_byteenable_1 (writeburst_byteenable_1),
      .writeburst_data         (writeburst_data),
      .readburst_do            (readburst_do),
      .readburst_address       (readburst_address),
      .readburst_dword_length  (readburst_dword_length),
      .readburst_byte_length   (readburst_byte_length),
      .readcode_do             (readcode_do),
      .readcode_address        (readcode_address),
      .cmd                     (link.dec)
   );

   // ------------------------------
   // Bus sequencer
   // ------------------------------
   avalon_burst_exec #(
      .CODE_BEATS (CODE_BEATS)
   ) u_exec (
      .clk               (clk),
      .rst_n             (rst_n),
      .cmd               (link.exe),
      .avm_waitrequest   (avm_waitrequest),
      .avm_readdatavalid (avm_readdatavalid),
      .avm_readdata      (avm_readdata),
      .avm_address       (avm_address),
      .avm_writedata     (avm_writedata),
      .avm_byteenable    (avm_byteenable),
      .avm_burstcount    (avm_burstcount),
      .avm_write         (avm_write),
      .avm_read          (avm_read),
      .writeburst_done   (writeburst_done),
      .readburst_done    (readburst_done),
      .readcode_done     (readcode_done)
   );

   // Read data assembly
   read_result_assemble u_result (
      .clk              (clk),
      .rst_n            (rst_n),
      .beat             (link.res),
      .readburst_data   (readburst_data),
      .readcode_partial (readcode_partial)
   );

endmodule

// ==== avalon_mem_vectors.txt ====
# kind addr dlen blen be0 be1 wdata exp_be exp_data, all hex
# kind 1 write, 2 read, 3 code line, 4 write, read and code at once
2 00000100 1 4 0 0 0 f A5A50040A5A50040A5A50040
2 00000103 1 1 0 0 0 8 A5A50040A5A50040A5A50040
2 00000206 1 2 0 0 0 c A5A50081A5A50081A5A50081
2 00000207 2 2 0 0 0 f A5A50082A5A50082A5A50081
2 00000305 1 3 0 0 0 e A5A500C1A5A500C1A5A500C1
2 00000306 2 3 0 0 0 f A5A500C2A5A500C2A5A500C1
2 00000400 3 a 0 0 0 f A5A50102A5A50101A5A50100
2 00000a01 1 2 0 0 0 6 A5A50280A5A50280A5A50280
2 00000a02 2 3 0 0 0 f A5A50281A5A50281A5A50280
1 00000500 1 0 3 0 ABCDEF11223344 0 0
2 00000500 1 4 0 0 0 f A5A53344A5A53344A5A53344
1 00000600 2 0 c 7 123456DEADBEEF 0 0
2 00000600 2 8 0 0 0 f A5123456A5123456DEAD0180
1 00000700 2 0 f f FFEEDDCCBBAA99 0 0
2 000006fc 3 c 0 0 0 f 00FFEEDDCCBBAA99A5A501BF
3 00000800 0 0 0 0 0 0 0
3 00000700 0 0 0 0 0 0 0
4 00000900 2 8 f 1 00007701020304 f A5A50277A5A5027701020304
4 00000b00 1 4 5 0 00000055AA55AA f A5AA02AAA5AA02AAA5AA02AA

// ==== compile.f ====
mem_bus_pkg.sv
mem_req_pkg.sv
mem_cmd_if.sv
mem_req_decode.sv
avalon_burst_exec.sv
read_result_assemble.sv
avalon_mem.sv
tb_avalon_mem.sv

// ==== mem_bus_pkg.sv ====
// ------------------------------
// Avalon-MM master side definitions
// ------------------------------
package mem_bus_pkg;

   // Dword address, bits 31:2 of the byte address
   localparam int AVM_ADDR_W = 30;

   // Data path and lane count
   localparam int AVM_DATA_W = 32;
   localparam int AVM_BE_W   = 4;

   // Burst count, up to 8 beats for a code line
   typedef logic [3:0] avm_burst_t;

   // ------------------------------
   // Master FSM states
   // ------------------------------
   // IDLE issues the command phase of every request
   // WRITE carries the second dword of a write burst
   // READ and READ_CODE wait for the returned beats
   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      WRITE     = 2'd1,
      READ      = 2'd2,
      READ_CODE = 2'd3
   } mem_state_t;

endpackage

// ==== mem_cmd_if.sv ====
`timescale 1ns/1ps

// ------------------------------
// Decode -> execute -> result link
// ------------------------------
interface mem_cmd_if;

   // Decoded request, combinational and always valid
   mem_req_pkg::mem_cmd_t cmd;

   // Read beat stream out of the sequencer
   logic                                 beat_valid;
   // Counts down, 0 on the last beat
   logic [2:0]                           beat_index;
   logic [mem_bus_pkg::AVM_DATA_W-1:0]   beat_data;
   // Dword length latched when the read was accepted
   mem_req_pkg::dword_len_t              beat_len;

   // Decode stage
   modport dec (
      output cmd
   );

   // Bus sequencer
   modport exe (
      input  cmd,
      output beat_valid,
      output beat_index,
      output beat_data,
      output beat_len
   );

   // Read data assembly
   modport res (
      input  beat_valid,
      input  beat_index,
      input  beat_data,
      input  beat_len
   );

endinterface

// ==== mem_req_decode.sv ====
`timescale 1ns/1ps

module mem_req_decode #(
   parameter int CODE_BEATS = 8
) (
   // Write request
   input  logic                      writeburst_do,
   input  logic [31:0]               writeburst_address,
   input  mem_req_pkg::dword_len_t   writeburst_dword_length,
   input  logic [3:0]                writeburst_byteenable_0,
   input  logic [3:0]                writeburst_byteenable_1,
   input  logic [55:0]               writeburst_data,

   // Data read request
   input  logic                      readburst_do,
   input  logic [31:0]               readburst_address,
   input  mem_req_pkg::dword_len_t   readburst_dword_length,
   input  mem_req_pkg::byte_len_t    readburst_byte_length,

   // Code line request
   input  logic                      readcode_do,
   input  logic [31:0]               readcode_address,

   // Decoded command out
   mem_cmd_if.dec                    cmd
);

   mem_req_pkg::mem_cmd_t               dec_cmd;
   mem_req_pkg::req_kind_t              kind;
   logic [1:0]                          rd_offset;
   logic [mem_bus_pkg::AVM_BE_W-1:0]    read_be;

   // ------------------------------
   // Arbitration
   // ------------------------------
   // Write first, then data read, then code
   always_comb begin
      if (writeburst_do) begin
         kind = mem_req_pkg::WRITE;
      end else if (readburst_do) begin
         kind = mem_req_pkg::READ;
      end else if (readcode_do) begin
         kind = mem_req_pkg::CODE;
      end else begin
         kind = mem_req_pkg::NONE;
      end
   end

   // ------------------------------
   // Read lane selection
   // ------------------------------
   assign rd_offset = readburst_address[1:0];

   // Lanes start at the byte offset
   // Anything crossing a dword edge reads all four lanes
   always_comb begin
      case (readburst_byte_length)
         4'd1: read_be = 4'b0001 << rd_offset;
         4'd2: read_be = (rd_offset <= 2'd2) ? (4'b0011 << rd_offset) : 4'b1111;
         4'd3: read_be = (rd_offset <= 2'd1) ? (4'b0111 << rd_offset) : 4'b1111;
         default: read_be = 4'b1111;
      endcase
   end

   // ------------------------------
   // Command fields
   // ------------------------------
   always_comb begin
      dec_cmd.kind    = kind;
      // Second dword of a write lands one dword up
      dec_cmd.addr_1  = writeburst_address[31:2] + 30'd1;
      dec_cmd.be_1    = writeburst_byteenable_1;
      dec_cmd.wdata_0 = writeburst_data[31:0];
      // Only 24 bits remain for the second word
      dec_cmd.wdata_1 = {8'd0, writeburst_data[55:32]};

      case (kind)
         mem_req_pkg::WRITE: begin
            dec_cmd.addr_0    = writeburst_address[31:2];
            dec_cmd.be_0      = writeburst_byteenable_0;
            // Each write dword goes out as its own transfer
            dec_cmd.burst     = 4'd1;
            dec_cmd.dword_len = writeburst_dword_length;
         end
         mem_req_pkg::READ: begin
            dec_cmd.addr_0    = readburst_address[31:2];
            dec_cmd.be_0      = read_be;
            dec_cmd.burst     = {2'b00, readburst_dword_length};
            dec_cmd.dword_len = readburst_dword_length;
         end
         default: begin
            // Code line, also the idle default
            dec_cmd.addr_0    = readcode_address[31:2];
            dec_cmd.be_0      = 4'b1111;
            dec_cmd.burst     = mem_bus_pkg::avm_burst_t'(CODE_BEATS);
            dec_cmd.dword_len = 2'd0;
         end
      endcase
   end

   assign cmd.cmd = dec_cmd;

endmodule

// ==== mem_req_pkg.sv ====
// ------------------------------
// Requester side definitions
// ------------------------------
package mem_req_pkg;

   // Winning request after arbitration
   typedef enum logic [1:0] {
      NONE  = 2'd0,
      WRITE = 2'd1,
      READ  = 2'd2,
      CODE  = 2'd3
   } req_kind_t;

   // Dword count of a burst, 1 to 3
   typedef logic [1:0] dword_len_t;

   // Byte count of a data read
   typedef logic [3:0] byte_len_t;

   // Decoded command, everything the bus sequencer needs
   typedef struct packed {
      req_kind_t                                kind;
      logic [mem_bus_pkg::AVM_ADDR_W-1:0]       addr_0;
      logic [mem_bus_pkg::AVM_ADDR_W-1:0]       addr_1;
      logic [mem_bus_pkg::AVM_BE_W-1:0]         be_0;
      logic [mem_bus_pkg::AVM_BE_W-1:0]         be_1;
      logic [mem_bus_pkg::AVM_DATA_W-1:0]       wdata_0;
      // Upper 8 bits always zero
      logic [mem_bus_pkg::AVM_DATA_W-1:0]       wdata_1;
      mem_bus_pkg::avm_burst_t                  burst;
      dword_len_t                               dword_len;
   } mem_cmd_t;

endpackage

// ==== read_result_assemble.sv ====
`timescale 1ns/1ps

module read_result_assemble (
   input  logic                                    clk,
   input  logic                                    rst_n,

   // Beat stream from the sequencer
   mem_cmd_if.res                                  beat,

   // Assembled data burst
   output logic [3*mem_bus_pkg::AVM_DATA_W-1:0]    readburst_data,
   // Live code beat
   output logic [mem_bus_pkg::AVM_DATA_W-1:0]      readcode_partial
);

   // Earlier beats of a data burst, named by beat index
   logic [mem_bus_pkg::AVM_DATA_W-1:0]    word_1;
   logic [mem_bus_pkg::AVM_DATA_W-1:0]    word_2;

   // ------------------------------
   // Beat capture
   // ------------------------------
   // Index 0 is never stored, it is the live beat at done
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_1 <= '0;
         word_2 <= '0;
      end else if (beat.beat_valid) begin
         if (beat.beat_index == 3'd2) begin
            word_2 <= beat.beat_data;
         end
         if (beat.beat_index == 3'd1) begin
            word_1 <= beat.beat_data;
         end
      end
   end

   // ------------------------------
   // Output assembly
   // ------------------------------
   // First dword returned ends up in the lowest word used
   // Unused upper words repeat the live beat
   always_comb begin
      case (beat.beat_len)
         2'd1: readburst_data = {beat.beat_data, beat.beat_data, beat.beat_data};
         2'd2: readburst_data = {beat.beat_data, beat.beat_data, word_1};
         default: readburst_data = {beat.beat_data, word_1, word_2};
      endcase
   end

   // Code beats go straight through
   assign readcode_partial = beat.beat_data;

endmodule

// ==== tb_avalon_mem.sv ====
`timescale 1ns/1ps

module tb_avalon_mem;

   localparam int CODE_BEATS = 8;

   // DUT ports
   logic clk, rst_n;
   logic writeburst_do, readburst_do, readcode_do;
   logic writeburst_done, readburst_done, readcode_done;
   logic [31:0] writeburst_address, readburst_address, readcode_address;
   logic [1:0] writeburst_dword_length, readburst_dword_length;
   logic [3:0] writeburst_byteenable_0, writeburst_byteenable_1, readburst_byte_length;
   logic [55:0] writeburst_data;
   logic [95:0] readburst_data;
   logic [31:0] readcode_partial, avm_writedata, avm_readdata;
   logic [31:2] avm_address;
   logic [3:0] avm_byteenable, avm_burstcount;
   logic avm_write, avm_read, avm_waitrequest, avm_readdatavalid;

   // Slave memory, one word per dword address
   logic [31:0] mem [0:1023];

   // Vector table, one entry per request line
   logic [3:0] vec_kind [0:63];
   logic [31:0] vec_addr [0:63];
   logic [1:0] vec_dlen [0:63];
   logic [3:0] vec_blen [0:63];
   logic [3:0] vec_be0 [0:63];
   logic [3:0] vec_be1 [0:63];
   logic [3:0] vec_exp_be [0:63];
   logic [55:0] vec_wdata [0:63];
   logic [95:0] vec_exp_data [0:63];
   logic [8*160-1:0] line;
   int n_vec, errors, fd, i;
   int unsigned seed, rnd;

   // Slave read burst in flight
   logic [29:0] rd_addr;
   int rd_left;

   // Bus snapshot for the stall check
   logic prev_stall;
   logic [71:0] prev_bus;
   logic [71:0] bus_now;

   assign bus_now = {avm_address, avm_writedata, avm_byteenable, avm_burstcount,
                     avm_write, avm_read};

   avalon_mem #(.CODE_BEATS (CODE_BEATS)) UUT (.*);

   // 20 ns clock
   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic report_mismatch(input string name, input logic [95:0] exp,
                                  input logic [95:0] act);
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
   endtask

   // All strobes low with no request
   task automatic check_idle();
      if ({avm_write, avm_read, writeburst_done, readburst_done, readcode_done} !== 5'b0)
         report_mismatch("{avm_write, avm_read, writeburst_done, readburst_done, readcode_done}",
            96'd0, {avm_write, avm_read, writeburst_done, readburst_done, readcode_done});
   endtask

   // ------------------------------
   // Avalon slave model
   // ------------------------------
   // Random stalls and gaps between read beats
   always @(posedge clk) begin
      if (!rst_n) begin
         rd_left = 0;
         avm_readdatavalid <= 1'b0;
      end else begin
         // Roughly two beats out of three cycles
         if (rd_left > 0 && ($urandom % 3) != 0) begin
            avm_readdatavalid <= 1'b1;
            avm_readdata <= mem[rd_addr[9:0]];
            rd_addr = rd_addr + 30'd1;
            rd_left--;
         end else begin
            avm_readdatavalid <= 1'b0;
         end
         // Byte lanes merge into the stored word
         if (avm_write && !avm_waitrequest) begin
            for (int b = 0; b < 4; b++)
               if (avm_byteenable[b])
                  mem[avm_address[11:2]][8*b +: 8] = avm_writedata[8*b +: 8];
         end
         // Accepted read starts a new burst
         if (avm_read && !avm_waitrequest) begin
            rd_addr = avm_address;
            rd_left = avm_burstcount;
         end
      end
      avm_waitrequest <= (($urandom % 4) == 0);
   end

   // Command outputs frozen while stalled
   always @(negedge clk) begin
      if (rst_n && prev_stall && bus_now !== prev_bus)
         report_mismatch("avm outputs under waitrequest", prev_bus, bus_now);
      prev_stall = rst_n && (avm_write || avm_read) && avm_waitrequest;
      prev_bus = bus_now;
   end

   // ------------------------------
   // One request line from the file
   // ------------------------------
   task automatic run_vector(input int v);
      int kind, wr_left, wr_beat, cd_count;
      int cyc, wr_cyc, rd_cyc, cd_cyc;
      logic wr_pend, rd_pend, cd_pend;
      logic [29:0] base, code_addr;
      kind = vec_kind[v];
      base = vec_addr[v][31:2];
      // Kind 4 raises all three requests together
      wr_pend = (kind == 1) || (kind == 4);
      rd_pend = (kind == 2) || (kind == 4);
      cd_pend = (kind == 3) || (kind == 4);
      wr_left = wr_pend ? vec_dlen[v] : 0;
      wr_beat = 0;
      cd_count = 0;
      cyc = 0;
      wr_cyc = 0;
      rd_cyc = 0;
      cd_cyc = 0;
      @(posedge clk);
      writeburst_address <= vec_addr[v];
      writeburst_dword_length <= vec_dlen[v];
      writeburst_byteenable_0 <= vec_be0[v];
      writeburst_byteenable_1 <= vec_be1[v];
      writeburst_data <= vec_wdata[v];
      readburst_address <= vec_addr[v];
      readburst_dword_length <= vec_dlen[v];
      readburst_byte_length <= vec_blen[v];
      readcode_address <= vec_addr[v];
      writeburst_do <= wr_pend;
      readburst_do <= rd_pend;
      readcode_do <= cd_pend;
      while (wr_pend || rd_pend || cd_pend || wr_left > 0) begin
         @(negedge clk);
         cyc++;
         // Write dword taken at the next edge
         if (avm_write && !avm_waitrequest) begin
            if (wr_left == 0) begin
               $display("ERROR: write issued at %0t with no write pending", $time);
               errors++;
            end else begin
               if (avm_address !== base + wr_beat)
                  report_mismatch("avm_address", base + wr_beat, avm_address);
               // Second dword carries the top 24 data bits zero-extended
               if (avm_writedata !== ((wr_beat == 0) ? vec_wdata[v][31:0] :
                                      {8'h00, vec_wdata[v][55:32]}))
                  report_mismatch("avm_writedata", (wr_beat == 0) ? vec_wdata[v][31:0] :
                                  {8'h00, vec_wdata[v][55:32]}, avm_writedata);
               if (avm_byteenable !== ((wr_beat == 0) ? vec_be0[v] : vec_be1[v]))
                  report_mismatch("avm_byteenable", (wr_beat == 0) ? vec_be0[v] : vec_be1[v],
                                  avm_byteenable);
               wr_beat++;
               wr_left--;
            end
         end
         // Read command phase, data burst before code line
         if (avm_read && !avm_waitrequest) begin
            if (avm_address !== base)
               report_mismatch("avm_address", base, avm_address);
            if (rd_pend) begin
               if (avm_burstcount !== vec_dlen[v])
                  report_mismatch("avm_burstcount", vec_dlen[v], avm_burstcount);
               if (avm_byteenable !== vec_exp_be[v])
                  report_mismatch("avm_byteenable", vec_exp_be[v], avm_byteenable);
            end else if (cd_pend) begin
               if (avm_burstcount !== CODE_BEATS)
                  report_mismatch("avm_burstcount", CODE_BEATS, avm_burstcount);
            end else begin
               $display("ERROR: read issued at %0t with no read pending", $time);
               errors++;
            end
         end
         if (writeburst_done) begin
            if (!wr_pend) begin
               $display("ERROR: writeburst_done at %0t with no write pending", $time);
               errors++;
            end else begin
               wr_pend = 1'b0;
               wr_cyc = cyc;
            end
         end
         if (readburst_done) begin
            if (!rd_pend) begin
               $display("ERROR: readburst_done at %0t with no read pending", $time);
               errors++;
            end else begin
               if (readburst_data !== vec_exp_data[v])
                  report_mismatch("readburst_data", vec_exp_data[v], readburst_data);
               rd_pend = 1'b0;
               rd_cyc = cyc;
            end
         end
         // Code beats follow memory from the line start
         if (readcode_done) begin
            if (!cd_pend) begin
               $display("ERROR: readcode_done at %0t with no code read pending", $time);
               errors++;
            end else begin
               code_addr = base + cd_count;
               if (readcode_partial !== mem[code_addr[9:0]])
                  report_mismatch("readcode_partial", mem[code_addr[9:0]],
                                  readcode_partial);
               if (cd_count == 0)
                  cd_cyc = cyc;
               cd_count++;
               if (cd_count == CODE_BEATS)
                  cd_pend = 1'b0;
            end
         end
         @(posedge clk);
         // Requests drop in the cycle after their done
         if (!wr_pend) begin
            writeburst_do <= 1'b0;
         end
         if (!rd_pend) begin
            readburst_do <= 1'b0;
         end
         if (!cd_pend) begin
            readcode_do <= 1'b0;
         end
      end
      if (kind == 4 && !(wr_cyc < rd_cyc && rd_cyc < cd_cyc)) begin
         $display("ERROR: priority order broken, write %0d, read %0d, code %0d",
                  wr_cyc, rd_cyc, cd_cyc);
         errors++;
      end
   endtask

   // Watchdog of 200 cycles per vector
   initial begin
      wait (n_vec > 0);
      repeat (n_vec * 200 + 20) @(posedge clk);
      $display("ERROR: run did not finish within %0d cycles", n_vec * 200 + 20);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      seed = 32'h5e6d;
      rnd = $urandom(seed);
      errors = 0;
      n_vec = 0;
      rst_n = 1'b0;
      writeburst_do = 1'b0;
      readburst_do = 1'b0;
      readcode_do = 1'b0;
      writeburst_address = '0;
      readburst_address = '0;
      readcode_address = '0;
      writeburst_dword_length = '0;
      readburst_dword_length = '0;
      writeburst_byteenable_0 = '0;
      writeburst_byteenable_1 = '0;
      readburst_byte_length = '0;
      writeburst_data = '0;
      avm_waitrequest = 1'b0;
      avm_readdatavalid = 1'b0;
      avm_readdata = '0;
      // Fill pattern from the full dword address
      for (i = 0; i < 1024; i++)
         mem[i] = i ^ 32'hA5A5_0000;
      fd = $fopen("avalon_mem_vectors.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open avalon_mem_vectors.txt");
         errors++;
      end else begin
         // Comment lines fail the scan and are skipped
         while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0 &&
                $sscanf(line, "%h %h %h %h %h %h %h %h %h", vec_kind[n_vec],
                        vec_addr[n_vec], vec_dlen[n_vec], vec_blen[n_vec], vec_be0[n_vec],
                        vec_be1[n_vec], vec_wdata[n_vec], vec_exp_be[n_vec],
                        vec_exp_data[n_vec]) == 9)
               n_vec++;
         end
         $fclose(fd);
      end
      // Strobes quiet through reset and the first idle cycles
      repeat (3) begin
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      rst_n <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         check_idle();
      end
      for (i = 0; i < n_vec; i++)
         run_vector(i);
      $display("Vectors run: %0d, errors: %0d", n_vec, errors);
      if (errors == 0 && n_vec > 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
